// File: design/thorIsa_defs.svh
// Thor ISA width definitions shared by the decode packages, decoders and stage
`ifndef THOR_ISA_DEFS_SVH
`define THOR_ISA_DEFS_SVH

// ========================================
// Instruction word geometry
// ========================================

// Every instruction is one 40-bit word
`define THOR_INSTR_W 40

// The primary opcode sits in the lowest bits of both formats
`define THOR_OPC_W 7

// The R2 format carries a function code in its top bits
`define THOR_FN_W 7

// Register specifiers select one of 64 registers
`define THOR_REG_W 6

// Width of the RI immediate field
`define THOR_IMM_W 21

// A prefix carries everything above its opcode as payload
`define THOR_PFX_W 33

// Integer datapath width
`define THOR_DATA_W 64

`endif

// File: design/thorIsaPkg.sv
// Thor ISA package with opcode and function encodings and the instruction formats
`include "thorIsa_defs.svh"

package thorIsaPkg;

	// ========================================
	// Opcodes and R2 function codes
	// ========================================

	// Integer and system opcodes occupy the low codes and memory ops the upper half
	typedef enum logic [`THOR_OPC_W-1:0] {
		OP_SYS   = 7'd0,
		OP_R2    = 7'd2,
		OP_ADDI  = 7'd4,
		OP_SUBFI = 7'd5,
		OP_CMPI  = 7'd6,
		OP_MULI  = 7'd7,
		OP_DIVI  = 7'd8,
		OP_ANDI  = 7'd9,
		OP_ORI   = 7'd10,
		OP_EORI  = 7'd11,
		OP_SLTI  = 7'd12,
		OP_SHIFT = 7'd13,
		OP_CSR   = 7'd14,
		OP_MOV   = 7'd15,
		OP_LDB   = 7'd64,
		OP_LDBU  = 7'd65,
		OP_LDW   = 7'd66,
		OP_LDWU  = 7'd67,
		OP_LDT   = 7'd68,
		OP_LDTU  = 7'd69,
		OP_LDO   = 7'd70,
		OP_LDX   = 7'd71,
		OP_STB   = 7'd80,
		OP_STW   = 7'd81,
		OP_STT   = 7'd82,
		OP_STO   = 7'd83,
		OP_STX   = 7'd84,
		OP_PFX   = 7'd124,
		OP_NOP   = 7'd127
	} opcode_t;

	// Function codes of register-register operations
	typedef enum logic [`THOR_FN_W-1:0] {
		FN_ADD  = 7'h04,
		FN_CMP  = 7'h05,
		FN_MUL  = 7'h06,
		FN_DIV  = 7'h07,
		FN_SUB  = 7'h08,
		FN_MULU = 7'h0E,
		FN_DIVU = 7'h0F,
		FN_AND  = 7'h10,
		FN_OR   = 7'h11,
		FN_EOR  = 7'h12,
		FN_ANDC = 7'h13,
		FN_NAND = 7'h14,
		FN_NOR  = 7'h15,
		FN_ENOR = 7'h16,
		FN_ORC  = 7'h17,
		FN_SEQ  = 7'h18,
		FN_SNE  = 7'h19,
		FN_SLT  = 7'h1A,
		FN_SLE  = 7'h1B,
		FN_SLTU = 7'h1C,
		FN_SLEU = 7'h1D
	} func_t;

	// ========================================
	// Instruction formats
	// ========================================

	// Register-register format with the function code at the top of the word
	typedef struct packed {
		func_t                  func;
		logic [7:0]             spare;
		logic [`THOR_REG_W-1:0] Rb;
		logic [`THOR_REG_W-1:0] Ra;
		logic [`THOR_REG_W-1:0] Rt;
		opcode_t                opcode;
	} r2Format_t;

	// Register-immediate format used by immediate ALU ops, loads and stores
	typedef struct packed {
		logic [`THOR_IMM_W-1:0] imm;
		logic [`THOR_REG_W-1:0] Ra;
		logic [`THOR_REG_W-1:0] Rt;
		opcode_t                opcode;
	} riFormat_t;

	// Both views share the opcode in the low bits so either may be used to dispatch
	typedef union packed {
		r2Format_t r2;
		riFormat_t ri;
	} instruction_t;

	// Bits a prefix supplies above the following instruction's immediate
	typedef logic [`THOR_PFX_W-1:0] pfxPayload_t;

endpackage

// File: design/thorDecodePkg.sv
// Decode result package with the memory access size and the decoded bundle
`include "thorIsa_defs.svh"

package thorDecodePkg;

	// Access sizes follow the byte, wyde, tetra and octa naming of the ISA
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} memSize_t;

	// ========================================
	// Bundle handed to the issue logic
	// ========================================

	// One bundle is produced per accepted non-prefix instruction
	typedef struct packed {
		logic                    isAlu;
		logic                    isLoad;
		logic                    isStore;
		logic                    isIndexed;
		logic                    memUnsigned;
		memSize_t                memSize;
		logic                    hasImm;
		logic [`THOR_REG_W-1:0]  Rt;
		logic [`THOR_REG_W-1:0]  Ra;
		logic [`THOR_REG_W-1:0]  Rb;
		logic [`THOR_DATA_W-1:0] imm;
	} decoded_t;

endpackage

// File: design/thorDecodeAlu.sv
// ALU-class decoder that flags instructions executed by the integer ALU
`timescale 1ns/1ps

module thorDecodeAlu (
	input  thorIsaPkg::instruction_t instr,
	output logic                     isAlu
);

	import thorIsaPkg::*;

	// The opcode is dispatched through the R2 view since both formats share it
	always_comb
	begin
		case (instr.r2.opcode)
			// System operations are handled outside the ALU
			OP_SYS:
				isAlu = 1'b0;
			// Only recognised function codes are ALU work
			OP_R2:
			begin
				case (instr.r2.func)
					FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB:
						isAlu = 1'b1;
					FN_MULU, FN_DIVU:
						isAlu = 1'b1;
					FN_AND, FN_OR, FN_EOR, FN_ANDC:
						isAlu = 1'b1;
					FN_NAND, FN_NOR, FN_ENOR, FN_ORC:
						isAlu = 1'b1;
					FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
						isAlu = 1'b1;
					default:
						isAlu = 1'b0;
				endcase
			end
			// Immediate forms of the arithmetic and logic ops
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI:
				isAlu = 1'b1;
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI:
				isAlu = 1'b1;
			// Shifts, CSR access and moves also pass through the ALU
			OP_SHIFT, OP_CSR, OP_MOV:
				isAlu = 1'b1;
			// Memory ops need the ALU to form their effective address
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO:
				isAlu = 1'b1;
			OP_LDX:
				isAlu = 1'b1;
			OP_STB, OP_STW, OP_STT, OP_STO:
				isAlu = 1'b1;
			OP_STX:
				isAlu = 1'b1;
			// Prefix and no-op occupy an ALU slot
			OP_PFX, OP_NOP:
				isAlu = 1'b1;
			// Unassigned opcodes are never ALU work
			default:
				isAlu = 1'b0;
		endcase
	end

endmodule

// File: design/thorDecodeMem.sv
// Load/store decoder giving access size, signedness and indexed addressing
`timescale 1ns/1ps

module thorDecodeMem (
	input  thorIsaPkg::instruction_t instr,
	output logic                     isLoad,
	output logic                     isStore,
	output logic                     isIndexed,
	output logic                     memUnsigned,
	output thorDecodePkg::memSize_t  memSize
);

	import thorIsaPkg::*;
	import thorDecodePkg::*;

	always_comb
	begin
		// Non-memory instructions leave every field clear
		isLoad      = 1'b0;
		isStore     = 1'b0;
		isIndexed   = 1'b0;
		memUnsigned = 1'b0;
		memSize     = SZ_BYTE;
		case (instr.ri.opcode)
			// ========================================
			// Loads
			// ========================================
			OP_LDB, OP_LDBU:
			begin
				isLoad      = 1'b1;
				memUnsigned = (instr.ri.opcode == OP_LDBU);
			end
			OP_LDW, OP_LDWU:
			begin
				isLoad      = 1'b1;
				memUnsigned = (instr.ri.opcode == OP_LDWU);
				memSize     = SZ_WYDE;
			end
			OP_LDT, OP_LDTU:
			begin
				isLoad      = 1'b1;
				memUnsigned = (instr.ri.opcode == OP_LDTU);
				memSize     = SZ_TETRA;
			end
			// Indexed loads take Rb as the second address register and move an octa
			OP_LDO, OP_LDX:
			begin
				isLoad    = 1'b1;
				isIndexed = (instr.ri.opcode == OP_LDX);
				memSize   = SZ_OCTA;
			end
			// ========================================
			// Stores
			// ========================================
			OP_STB:
				isStore = 1'b1;
			OP_STW:
			begin
				isStore = 1'b1;
				memSize = SZ_WYDE;
			end
			OP_STT:
			begin
				isStore = 1'b1;
				memSize = SZ_TETRA;
			end
			OP_STO, OP_STX:
			begin
				isStore   = 1'b1;
				isIndexed = (instr.ri.opcode == OP_STX);
				memSize   = SZ_OCTA;
			end
			default:
				isLoad = 1'b0;
		endcase
	end

endmodule

// File: design/thorDecodeImm.sv
// Immediate decoder that sign-extends the RI immediate and applies prefix bits
`timescale 1ns/1ps
`include "thorIsa_defs.svh"

module thorDecodeImm (
	input  thorIsaPkg::instruction_t  instr,
	input  logic                      pfxPending,
	input  thorIsaPkg::pfxPayload_t   pfxPayload,
	output logic                      hasImm,
	output logic [`THOR_DATA_W-1:0]   imm
);

	import thorIsaPkg::*;

	// Width of the immediate once a prefix has been placed above it
	localparam int wideW = `THOR_IMM_W + `THOR_PFX_W;

	logic [wideW-1:0] wideImm;

	// Opcodes whose RI immediate field is an operand
	always_comb
	begin
		case (instr.ri.opcode)
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI:
				hasImm = 1'b1;
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI, OP_SHIFT, OP_CSR:
				hasImm = 1'b1;
			// Displacement of the non-indexed loads and stores
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO:
				hasImm = 1'b1;
			OP_STB, OP_STW, OP_STT, OP_STO:
				hasImm = 1'b1;
			default:
				hasImm = 1'b0;
		endcase
	end

	// The prefix payload extends the field upward
	assign wideImm = {pfxPayload, instr.ri.imm};

	always_comb
	begin
		if (!hasImm)
			imm = '0;
		else if (pfxPending)
			imm = {{(`THOR_DATA_W - wideW){wideImm[wideW-1]}}, wideImm};
		else
			imm = {{(`THOR_DATA_W - `THOR_IMM_W){instr.ri.imm[`THOR_IMM_W-1]}}, instr.ri.imm};
	end

endmodule

// File: design/thorDecodeStage.sv
// Registered decode stage that tracks prefixes and emits one bundle per instruction
`timescale 1ns/1ps
`include "thorIsa_defs.svh"

module thorDecodeStage (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     instrValid,
	input  thorIsaPkg::instruction_t instr,
	output logic                     outValid,
	output thorDecodePkg::decoded_t  decoded
);

	import thorIsaPkg::*;
	import thorDecodePkg::*;

	// Decoder outputs for the instruction on the input this cycle
	logic                    aluHit;
	logic                    memLoad;
	logic                    memStore;
	logic                    memIndexed;
	logic                    memUns;
	memSize_t                memSz;
	logic                    immHas;
	logic [`THOR_DATA_W-1:0] immVal;

	// Prefix state waiting for the next real instruction
	logic        pfxPending;
	pfxPayload_t pfxPayload;

	logic     isPfx;
	logic     useRb;
	decoded_t nextBundle;

	// ========================================
	// Combinational decoders
	// ========================================

	thorDecodeAlu thorDecodeAlu_inst (
		.instr (instr),
		.isAlu (aluHit)
	);

	thorDecodeMem thorDecodeMem_inst (
		.instr       (instr),
		.isLoad      (memLoad),
		.isStore     (memStore),
		.isIndexed   (memIndexed),
		.memUnsigned (memUns),
		.memSize     (memSz)
	);

	thorDecodeImm thorDecodeImm_inst (
		.instr      (instr),
		.pfxPending (pfxPending),
		.pfxPayload (pfxPayload),
		.hasImm     (immHas),
		.imm        (immVal)
	);

	assign isPfx = (instr.ri.opcode == OP_PFX);

	// Rb is only a real operand for R2 ops and indexed memory access
	assign useRb = (instr.r2.opcode == OP_R2) || memIndexed;

	always_comb
	begin
		nextBundle.isAlu       = aluHit;
		nextBundle.isLoad      = memLoad;
		nextBundle.isStore     = memStore;
		nextBundle.isIndexed   = memIndexed;
		nextBundle.memUnsigned = memUns;
		nextBundle.memSize     = memSz;
		nextBundle.hasImm      = immHas;
		nextBundle.Rt          = instr.r2.Rt;
		nextBundle.Ra          = instr.r2.Ra;
		nextBundle.Rb          = useRb ? instr.r2.Rb : '0;
		nextBundle.imm         = immVal;
	end

	// ========================================
	// Output register and prefix tracking
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outValid   <= 1'b0;
			pfxPending <= 1'b0;
			decoded    <= '0;
		end
		else
		begin
			// A prefix is absorbed here and never reaches the consumer
			outValid <= instrValid && !isPfx;
			if (instrValid)
			begin
				pfxPending <= isPfx;
				if (!isPfx)
					decoded <= nextBundle;
			end
		end
	end

	// Everything above the opcode is kept and a later prefix overwrites it
	always_ff @(posedge clk)
	begin
		if (instrValid && isPfx)
			pfxPayload <= {instr.ri.imm, instr.ri.Ra, instr.ri.Rt};
	end

endmodule

// File: sim/thorDecodeTable.svh
// Decode stage stimulus table of instruction words with their expected flags and immediates
// Columns are the instruction word, the expected flags and the expected imm
// Flags read isAlu, isLoad, isStore, isIndexed, memUnsigned, memSize, hasImm from left to right
// Rt, Ra and Rb are checked against the word itself by the register-field rule

// ALU class of the system opcode and of R2 with listed and unlisted function codes
addEntry(riWord(OP_SYS, 6'd1, 6'd2, 21'h00010), 8'b0_0_0_0_0_00_0, 64'h0);
addEntry(r2Word(FN_ADD, 6'd3, 6'd4, 6'd5), 8'b1_0_0_0_0_00_0, 64'h0);
addEntry(r2Word(FN_SLEU, 6'd6, 6'd7, 6'd8), 8'b1_0_0_0_0_00_0, 64'h0);
addEntry(r2Word(7'h7F, 6'd9, 6'd10, 6'd11), 8'b0_0_0_0_0_00_0, 64'h0);
// Immediate ALU forms with both signs of the 21-bit field
addEntry(riWord(OP_ADDI, 6'd1, 6'd2, 21'h00005), 8'b1_0_0_0_0_00_1, 64'h5);
addEntry(riWord(OP_SUBFI, 6'd2, 6'd3, 21'h1FFFFE), 8'b1_0_0_0_0_00_1, 64'hFFFFFFFFFFFFFFFE);
addEntry(riWord(OP_CMPI, 6'd4, 6'd5, 21'h00100), 8'b1_0_0_0_0_00_1, 64'h100);
addEntry(riWord(OP_MULI, 6'd6, 6'd7, 21'h0FFFFF), 8'b1_0_0_0_0_00_1, 64'hFFFFF);
addEntry(riWord(OP_DIVI, 6'd8, 6'd9, 21'h100000), 8'b1_0_0_0_0_00_1, 64'hFFFFFFFFFFF00000);
addEntry(riWord(OP_ANDI, 6'd10, 6'd11, 21'h00FF0), 8'b1_0_0_0_0_00_1, 64'hFF0);
addEntry(riWord(OP_ORI, 6'd12, 6'd13, 21'h1ABCDE), 8'b1_0_0_0_0_00_1, 64'hFFFFFFFFFFFABCDE);
addEntry(riWord(OP_EORI, 6'd14, 6'd15, 21'h0ABCDE), 8'b1_0_0_0_0_00_1, 64'hABCDE);
addEntry(riWord(OP_SLTI, 6'd16, 6'd17, 21'h1FFFFF), 8'b1_0_0_0_0_00_1, 64'hFFFFFFFFFFFFFFFF);
addEntry(riWord(OP_SHIFT, 6'd18, 6'd19, 21'h0003F), 8'b1_0_0_0_0_00_1, 64'h3F);
addEntry(riWord(OP_CSR, 6'd20, 6'd21, 21'h00C00), 8'b1_0_0_0_0_00_1, 64'hC00);
// Moves, no-ops and unassigned codes carry no immediate even with a nonzero field
addEntry(riWord(OP_MOV, 6'd22, 6'd23, 21'h12345), 8'b1_0_0_0_0_00_0, 64'h0);
addEntry(riWord(OP_NOP, 6'd24, 6'd25, 21'h0F0F0), 8'b1_0_0_0_0_00_0, 64'h0);
addEntry(riWord(7'd50, 6'd26, 6'd27, 21'h00777), 8'b0_0_0_0_0_00_0, 64'h0);
// Loads over every size, signed and unsigned, then the indexed octa
addEntry(riWord(OP_LDB, 6'd30, 6'd31, 21'h00008), 8'b1_1_0_0_0_00_1, 64'h8);
addEntry(riWord(OP_LDBU, 6'd32, 6'd33, 21'h00008), 8'b1_1_0_0_1_00_1, 64'h8);
addEntry(riWord(OP_LDW, 6'd34, 6'd35, 21'h00010), 8'b1_1_0_0_0_01_1, 64'h10);
addEntry(riWord(OP_LDWU, 6'd36, 6'd37, 21'h00010), 8'b1_1_0_0_1_01_1, 64'h10);
addEntry(riWord(OP_LDT, 6'd38, 6'd39, 21'h1FFFFC), 8'b1_1_0_0_0_10_1, 64'hFFFFFFFFFFFFFFFC);
addEntry(riWord(OP_LDTU, 6'd40, 6'd41, 21'h00020), 8'b1_1_0_0_1_10_1, 64'h20);
addEntry(riWord(OP_LDO, 6'd42, 6'd43, 21'h00040), 8'b1_1_0_0_0_11_1, 64'h40);
addEntry(riWord(OP_LDX, 6'd44, 6'd45, 21'h0002A), 8'b1_1_0_1_0_11_0, 64'h0);
// Stores, where only the indexed form drops the displacement
addEntry(riWord(OP_STB, 6'd46, 6'd47, 21'h1FFFF0), 8'b1_0_1_0_0_00_1, 64'hFFFFFFFFFFFFFFF0);
addEntry(riWord(OP_STW, 6'd48, 6'd49, 21'h00002), 8'b1_0_1_0_0_01_1, 64'h2);
addEntry(riWord(OP_STT, 6'd50, 6'd51, 21'h00004), 8'b1_0_1_0_0_10_1, 64'h4);
addEntry(riWord(OP_STO, 6'd52, 6'd53, 21'h00008), 8'b1_0_1_0_0_11_1, 64'h8);
addEntry(riWord(OP_STX, 6'd54, 6'd55, 21'h00015), 8'b1_0_1_1_0_11_0, 64'h0);
templateCount = vecs.size();
// An idle prefix word must not leave anything pending
addIdle(riWord(OP_PFX, 6'd1, 6'd1, 21'h00001));
addEntry(riWord(OP_ADDI, 6'd1, 6'd2, 21'h00005), 8'b1_0_0_0_0_00_1, 64'h5);
// A prefix widens only the next instruction
addEntry(riWord(OP_PFX, 6'd0, 6'd0, 21'h00001), 8'b0_0_0_0_0_00_0, 64'h0);
addEntry(riWord(OP_ADDI, 6'd1, 6'd2, 21'h00005), 8'b1_0_0_0_0_00_1, 64'h200000005);
addEntry(riWord(OP_ADDI, 6'd1, 6'd2, 21'h00005), 8'b1_0_0_0_0_00_1, 64'h5);
// The second prefix replaces the first and its top bit sign-extends
addEntry(riWord(OP_PFX, 6'd0, 6'd0, 21'h00001), 8'b0_0_0_0_0_00_0, 64'h0);
addEntry(riWord(OP_PFX, 6'd63, 6'd63, 21'h100000), 8'b0_0_0_0_0_00_0, 64'h0);
addEntry(riWord(OP_LDB, 6'd4, 6'd5, 21'h1FFFFF), 8'b1_1_0_0_0_00_1, 64'hFFE00001FFFFFFFF);
addEntry(riWord(OP_LDB, 6'd4, 6'd5, 21'h1FFFFF), 8'b1_1_0_0_0_00_1, 64'hFFFFFFFFFFFFFFFF);
// A pending prefix survives an idle cycle
addEntry(riWord(OP_PFX, 6'd0, 6'd0, 21'h00001), 8'b0_0_0_0_0_00_0, 64'h0);
addIdle(riWord(OP_NOP, 6'd0, 6'd0, 21'h00000));
addEntry(riWord(OP_ADDI, 6'd7, 6'd8, 21'h00005), 8'b1_0_0_0_0_00_1, 64'h200000005);
// An instruction without an immediate still consumes the prefix
addEntry(riWord(OP_PFX, 6'd0, 6'd0, 21'h00001), 8'b0_0_0_0_0_00_0, 64'h0);
addEntry(r2Word(FN_SUB, 6'd1, 6'd2, 6'd3), 8'b1_0_0_0_0_00_0, 64'h0);
addEntry(riWord(OP_ADDI, 6'd1, 6'd2, 21'h00005), 8'b1_0_0_0_0_00_1, 64'h5);

// File: sim/thorDecodeTb.sv
// Testbench for the decode stage driven by a stimulus table and a random extension
`timescale 1ns/1ps
`include "thorIsa_defs.svh"

module thorDecodeTb;

	import thorIsaPkg::*;
	import thorDecodePkg::*;

	// One row holds the stimulus and what the stage should return for it
	typedef struct packed {
		logic                     valid;
		logic                     expOut;
		logic [`THOR_INSTR_W-1:0] word;
		logic [7:0]               flags;
		logic [`THOR_DATA_W-1:0]  expImm;
	} entry_t;

	logic         clk;
	logic         rst;
	logic         instrValid;
	instruction_t instr;
	logic         outValid;
	decoded_t     decoded;

	entry_t      vecs[$];
	int          templateCount;
	int          errCount;
	int          checkCount;
	logic [31:0] rngState;
	logic        tableReady;

	thorDecodeStage thorDecodeStage_inst (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.outValid   (outValid),
		.decoded    (decoded)
	);

	// ========================================
	// Word builders and the reference rules
	// ========================================

	function automatic logic [`THOR_INSTR_W-1:0] riWord(input logic [6:0] opc,
		input logic [5:0] rt, input logic [5:0] ra, input logic [20:0] imm);
		return {imm, ra, rt, opc};
	endfunction

	// The spare byte of the R2 format stays zero
	function automatic logic [`THOR_INSTR_W-1:0] r2Word(input logic [6:0] fn,
		input logic [5:0] rt, input logic [5:0] ra, input logic [5:0] rb);
		return {fn, 8'h00, rb, ra, rt, OP_R2};
	endfunction

	function automatic logic [`THOR_DATA_W-1:0] signExtend21(input logic [20:0] field);
		return {{43{field[20]}}, field};
	endfunction

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Rt and Ra always follow the word and Rb only for R2 and indexed forms
	function automatic decoded_t expectedBundle(input entry_t e);
		decoded_t b;
		logic     useRb;
		useRb = (e.word[6:0] == OP_R2) || e.flags[4];
		b = {e.flags, e.word[12:7], e.word[18:13], useRb ? e.word[24:19] : 6'd0, e.expImm};
		return b;
	endfunction

	// ========================================
	// Table construction
	// ========================================

	task automatic addEntry(input logic [`THOR_INSTR_W-1:0] word, input logic [7:0] flags,
		input logic [`THOR_DATA_W-1:0] expImm);
		entry_t e;
		e.valid  = 1'b1;
		// The stage swallows a prefix and returns nothing for it
		e.expOut = (word[6:0] != OP_PFX);
		e.word   = word;
		e.flags  = flags;
		e.expImm = expImm;
		vecs.push_back(e);
	endtask

	task automatic addIdle(input logic [`THOR_INSTR_W-1:0] word);
		entry_t e;
		e = '0;
		e.word = word;
		vecs.push_back(e);
	endtask

	task automatic buildTable();
		`include "thorDecodeTable.svh"
	endtask

	// Copies of the opcode rows with fresh register fields and immediates
	task automatic addRandomEntries(input int count);
		entry_t                   base;
		logic [31:0]              r1;
		logic [31:0]              r2;
		logic [`THOR_INSTR_W-1:0] word;
		logic [`THOR_DATA_W-1:0]  imm;
		for (int k = 0; k < count; k++)
		begin
			rngState = nextRandom(rngState);
			r1 = rngState;
			rngState = nextRandom(rngState);
			r2 = rngState;
			base = vecs[r1[15:0] % templateCount];
			if (base.word[6:0] == OP_R2)
				word = r2Word(base.word[39:33], r1[21:16], r1[27:22], r2[5:0]);
			else
				word = riWord(base.word[6:0], r1[21:16], r1[27:22], r2[20:0]);
			imm = base.flags[0] ? signExtend21(word[39:19]) : '0;
			// Roughly one row in eight becomes an idle gap
			if (r2[31:29] == 3'd0)
				addIdle(word);
			else
				addEntry(word, base.flags, imm);
		end
	endtask

	task automatic compareValue(input string what, input logic [95:0] got,
		input logic [95:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("[ERROR] %0t ns: %s mismatch, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ========================================
	// Clock, stimulus loop and watchdog
	// ========================================

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		entry_t   prev;
		decoded_t lastBundle;
		rst        = 1'b1;
		// A valid instruction is offered throughout reset and must not reach the output
		instrValid = 1'b1;
		instr      = riWord(OP_ADDI, 6'd3, 6'd4, 21'h00123);
		errCount   = 0;
		checkCount = 0;
		rngState   = 32'hda69;
		tableReady = 1'b0;
		buildTable();
		addRandomEntries(24);
		tableReady = 1'b1;
		repeat (3)
		begin
			@(posedge clk);
			#2;
			compareValue("outValid in reset", 96'(outValid), 96'(1'b0));
		end
		rst        = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		compareValue("decoded after reset", 96'(decoded), 96'(0));
		prev       = '0;
		lastBundle = '0;
		// Each pass checks the response to the row driven one cycle earlier
		for (int i = 0; i <= vecs.size(); i++)
		begin
			@(posedge clk);
			#2;
			compareValue($sformatf("outValid for row %0d", i - 1), 96'(outValid),
				96'(prev.expOut));
			if (prev.expOut)
				lastBundle = expectedBundle(prev);
			compareValue($sformatf("bundle for row %0d", i - 1), 96'(decoded),
				96'(lastBundle));
			if (i < vecs.size())
				prev = vecs[i];
			else
				prev = '0;
			instrValid = prev.valid;
			instr      = prev.word;
		end
		$display("Decode checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Allows the whole table plus a margin of twenty cycles
	initial
	begin
		wait (tableReady);
		#((vecs.size() + 20) * 40);
		$display("Watchdog expired before the stimulus table was finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim.f
+incdir+design
+incdir+sim
design/thorIsaPkg.sv
design/thorDecodePkg.sv
design/thorDecodeAlu.sv
design/thorDecodeMem.sv
design/thorDecodeImm.sv
design/thorDecodeStage.sv
sim/thorDecodeTb.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= thorDecodeTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and search the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"
	@echo "Overridable variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
